/* Makefile */
# Verilator build and run for the radar scope testbench

VERILATOR ?= verilator
TOP       ?= radar_scope_tb
FILELIST  ?= radar_scope.f
MDIR      ?= obj_dir
PASS_MSG  ?= Everything OK
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: run build lint clean

# default target: build, run, then search the output for the pass message
run: build
	@out=$$(./$(MDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR)

/* design/polar_grid.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module polar_grid import scope_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   input  pos_t pos,
   input  logic active,
   output rgb_t color
);

   localparam int RINGS [6] = '{`RING_1, `RING_2, `RING_3, `RING_4, `RING_5, `RING_6};

   logic signed [31:0] x;
   logic signed [31:0] y;
   logic signed [31:0] d2;
   logic signed [31:0] t15;
   logic signed [31:0] t45;
   logic signed [31:0] t75;
   logic               on_band;
   logic               on_line;
   logic               on_ring;

   function automatic logic near_line(input logic signed [31:0] resid);
      logic signed [31:0] mag;
      mag = (resid < 0) ? -resid : resid;
      return mag < (`GRID_LINE_W / 2);
   endfunction

   ////////////////////////////////////////
   // distance and tan projections
   ////////////////////////////////////////
   assign x   = 32'(pos.x);
   assign y   = 32'(pos.y);
   // squared distance from origin, avoids a square root
   assign d2  = x * x + y * y;
   // tan 15 about 17/64
   assign t15 = (x * 32'sd17) >>> 6;
   assign t45 = x;
   // tan 75 about 240/64
   assign t75 = (x * 32'sd240) >>> 6;

   // boundary band along the bottom
   assign on_band = (y < `VERT_OFFSET);

   // 15/45/75 use t - y, 165/135/105 mirror with t + y
   assign on_line = near_line(t15 - y) | near_line(t15 + y) |
                    near_line(t45 - y) | near_line(t45 + y) |
                    near_line(t75 - y) | near_line(t75 + y);

   ////////////////////////////////////////
   // range rings
   ////////////////////////////////////////
   always_comb begin
      on_ring = 1'b0;
      for (int i = 0; i < 6; i++) begin
         // band of squared distance around each radius
         if (d2 >= (RINGS[i] - `RING_W) * (RINGS[i] - `RING_W) &&
             d2 <= (RINGS[i] + `RING_W) * (RINGS[i] + `RING_W))
            on_ring = 1'b1;
      end
      // top semicircle only
      if (y < 0)
         on_ring = 1'b0;
   end

   ////////////////////////////////////////
   // stage 2 colour register
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n)
         color <= rgb_t'(`BLANK_COLOR);
      else if (!active)
         color <= rgb_t'(`BLANK_COLOR);
      else if (on_band || on_line || on_ring)
         color <= rgb_t'(`GRID_COLOR);
      else
         color <= rgb_t'(`BLANK_COLOR);
   end

endmodule

/* design/radar_scope_top.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module radar_scope_top import scope_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cmd_valid,
   output logic        cmd_ready,
   input  target_cmd_t cmd,
   output rgb_t        pixel,
   output sync_t       video_sync
);

   localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};

   pos_t  pos_s1;
   sync_t sync_s1;
   logic  vblank_s1;
   pos_t  pos_s3;
   rgb_t  grid_s2;

   ////////////////////////////////////////
   // stage 1 raster
   ////////////////////////////////////////
   raster_timing raster_timing_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .pos       (pos_s1),
      .sync      (sync_s1),
      .in_vblank (vblank_s1)
   );

   ////////////////////////////////////////
   // stage 2 grid, stage 3 overlay
   ////////////////////////////////////////
   polar_grid polar_grid_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .pos    (pos_s1),
      .active (sync_s1.active),
      .color  (grid_s2)
   );

   target_overlay target_overlay_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd        (cmd),
      .in_vblank  (vblank_s1),
      .pos        (pos_s1),
      .active     (sync_s1.active),
      .grid_color (grid_s2),
      .pixel      (pixel)
   );

   // sync rides alongside the pixel pipe, idle during reset
   stage_delay #(.PAYLOAD_T(sync_t), .DEPTH(2), .RESET_VAL(SYNC_IDLE)) sync_delay_i (
      .clk   (clk),
      .rst_n (rst_n),
      .din   (sync_s1),
      .dout  (video_sync)
   );

   // coordinate of the pixel currently leaving
   stage_delay #(.PAYLOAD_T(pos_t), .DEPTH(2)) pos_delay_i (
      .clk   (clk),
      .rst_n (rst_n),
      .din   (pos_s1),
      .dout  (pos_s3)
   );

   // an active pixel leaving inside the bottom band always carries colour
   a_band_drawn: assert property (@(posedge clk) disable iff (!rst_n)
      video_sync.active && pos_s3.y < $signed(12'(`VERT_OFFSET)) |->
         pixel != rgb_t'(`BLANK_COLOR));

endmodule

/* design/raster_timing.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module raster_timing import scope_pkg::*; (
   input  logic  clk,
   input  logic  rst_n,
   output pos_t  pos,
   output sync_t sync,
   output logic  in_vblank
);

   logic [9:0]         hcount;
   logic [9:0]         vcount;
   logic signed [11:0] scope_x;
   logic signed [11:0] scope_y;

   ////////////////////////////////////////
   // frame counters
   ////////////////////////////////////////

   // advance every clock, vcount steps at the end of each line
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hcount <= '0;
         vcount <= '0;
      end else if (hcount == 10'(`H_TOTAL - 1)) begin
         hcount <= '0;
         if (vcount == 10'(`V_TOTAL - 1))
            vcount <= '0;
         else
            vcount <= vcount + 10'd1;
      end else begin
         hcount <= hcount + 10'd1;
      end
   end

   // screen to scope mapping, y flipped so it grows upward
   assign scope_x = $signed({2'b00, hcount}) - $signed(12'(`ORIGIN_X));
   assign scope_y = $signed(12'(`ORIGIN_Y)) - $signed({2'b00, vcount});

   ////////////////////////////////////////
   // stage 1 registers
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pos       <= '0;
         // syncs idle high, nothing active
         sync      <= '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};
         in_vblank <= 1'b0;
      end else begin
         pos.x       <= scope_x;
         pos.y       <= scope_y;
         sync.hsync  <= !(hcount >= 10'(`H_SYNC_START) && hcount < 10'(`H_SYNC_END));
         sync.vsync  <= !(vcount >= 10'(`V_SYNC_START) && vcount < 10'(`V_SYNC_END));
         sync.active <= (hcount < 10'(`H_ACTIVE)) && (vcount < 10'(`V_ACTIVE));
         in_vblank   <= (vcount >= 10'(`V_ACTIVE));
      end
   end

   // horizontal counter stays inside the line
   a_hcount_range: assert property (@(posedge clk) disable iff (!rst_n)
      hcount < 10'(`H_TOTAL));

endmodule

/* design/scope_config.svh */
`ifndef SCOPE_CONFIG_SVH
`define SCOPE_CONFIG_SVH

////////////////////////////////////////
// raster timing, 640x480 at 800x525
////////////////////////////////////////
`define H_ACTIVE      640
`define H_TOTAL       800
`define H_SYNC_START  656
`define H_SYNC_END    752
`define V_ACTIVE      480
`define V_TOTAL       525
`define V_SYNC_START  490
`define V_SYNC_END    492

////////////////////////////////////////
// scope geometry
////////////////////////////////////////
// screen position of scope origin, y grows upward from here
`define ORIGIN_X      320
`define ORIGIN_Y      470
// height of the bottom boundary band
`define VERT_OFFSET   4
// full width of a radial line window
`define GRID_LINE_W   4
// range ring radii in pixels
`define RING_1        40
`define RING_2        80
`define RING_3        120
`define RING_4        160
`define RING_5        200
`define RING_6        240
// half width of a ring band
`define RING_W        2

////////////////////////////////////////
// colours and markers
////////////////////////////////////////
`define GRID_COLOR    24'hFF_00_00
`define BLANK_COLOR   24'h00_00_00
`define TARGET_COLOR  24'h00_FF_00
// half size of the marker square
`define MARK_HALF     3
`define NUM_TARGETS   4

`endif

/* design/scope_pkg.sv */
package scope_pkg;

   ////////////////////////////////////////
   // video payloads
   ////////////////////////////////////////

   // 24-bit colour, red in the top byte
   typedef struct packed {
      logic [7:0] red;
      logic [7:0] green;
      logic [7:0] blue;
   } rgb_t;

   // scope coordinate, origin at bottom centre
   typedef struct packed {
      logic signed [11:0] x;
      logic signed [11:0] y;
   } pos_t;

   // hsync and vsync are active low
   typedef struct packed {
      logic hsync;
      logic vsync;
      logic active;
   } sync_t;

   ////////////////////////////////////////
   // target command port
   ////////////////////////////////////////

   // one command loads one marker slot
   typedef struct packed {
      logic [1:0]         slot;
      logic               enable;
      logic signed [11:0] x;
      logic signed [11:0] y;
   } target_cmd_t;

endpackage

/* design/stage_delay.sv */
`timescale 1ns/1ps

module stage_delay #(
   parameter type      PAYLOAD_T = logic [7:0],
   parameter int       DEPTH     = 2,
   parameter PAYLOAD_T RESET_VAL = '0
) (
   input  logic     clk,
   input  logic     rst_n,
   input  PAYLOAD_T din,
   output PAYLOAD_T dout
);

   // chain[0] is the first register after din
   PAYLOAD_T chain [DEPTH];

   ////////////////////////////////////////
   // shift chain
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < DEPTH; i++)
            chain[i] <= RESET_VAL;
      end else begin
         chain[0] <= din;
         // no iterations when depth is one
         for (int i = 1; i < DEPTH; i++)
            chain[i] <= chain[i-1];
      end
   end

   // oldest entry leaves
   assign dout = chain[DEPTH-1];

endmodule

/* design/target_overlay.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module target_overlay import scope_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cmd_valid,
   output logic        cmd_ready,
   input  target_cmd_t cmd,
   input  logic        in_vblank,
   input  pos_t        pos,
   input  logic        active,
   input  rgb_t        grid_color,
   output rgb_t        pixel
);

   logic [`NUM_TARGETS-1:0]       slot_en;
   pos_t [`NUM_TARGETS-1:0]       slot_pos;
   logic                          cmd_fire;
   logic                          any_hit;
   logic                          hit_s2;
   logic                          active_s2;

   // true when two coordinates are within the marker half size
   function automatic logic within_mark(input logic signed [11:0] a,
                                        input logic signed [11:0] b);
      logic signed [12:0] diff;
      diff = 13'(a) - 13'(b);
      if (diff < 0)
         diff = -diff;
      return diff <= 13'sd`MARK_HALF;
   endfunction

   ////////////////////////////////////////
   // command port and slot registers
   ////////////////////////////////////////

   // accept only in vertical blank so markers never change mid frame
   assign cmd_ready = in_vblank;
   assign cmd_fire  = cmd_valid && cmd_ready;

   // enable bits are control state
   always_ff @(posedge clk) begin
      if (!rst_n)
         slot_en <= '0;
      else if (cmd_fire)
         slot_en[cmd.slot] <= cmd.enable;
   end

   // positions are payload, only meaningful when enabled
   always_ff @(posedge clk) begin
      if (cmd_fire) begin
         slot_pos[cmd.slot].x <= cmd.x;
         slot_pos[cmd.slot].y <= cmd.y;
      end
   end

   ////////////////////////////////////////
   // stage 2 hit test
   ////////////////////////////////////////
   always_comb begin
      any_hit = 1'b0;
      for (int i = 0; i < `NUM_TARGETS; i++) begin
         // square marker, both axes inside the half size
         if (slot_en[i] && within_mark(pos.x, slot_pos[i].x) &&
             within_mark(pos.y, slot_pos[i].y))
            any_hit = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hit_s2    <= 1'b0;
         active_s2 <= 1'b0;
      end else begin
         hit_s2    <= any_hit;
         active_s2 <= active;
      end
   end

   ////////////////////////////////////////
   // stage 3 colour select
   ////////////////////////////////////////
   // grid_color already carries stage 2 timing and is blank off screen
   always_ff @(posedge clk) begin
      if (!rst_n)
         pixel <= rgb_t'(`BLANK_COLOR);
      else if (active_s2 && hit_s2)
         pixel <= rgb_t'(`TARGET_COLOR);
      else
         pixel <= grid_color;
   end

   // master holds the command while stalled
   a_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));
   // slot contents frozen outside vertical blank
   a_slots_frozen: assert property (@(posedge clk) disable iff (!rst_n)
      !in_vblank |=> $stable(slot_en) && $stable(slot_pos));

endmodule

/* radar_scope.f */
+incdir+design
+incdir+verif
design/scope_pkg.sv
design/raster_timing.sv
design/stage_delay.sv
design/polar_grid.sv
design/target_overlay.sv
design/radar_scope_top.sv
verif/radar_scope_tb.sv

/* verif/scope_model.svh */
`ifndef SCOPE_MODEL_SVH
`define SCOPE_MODEL_SVH

////////////////////////////////////////
// reference grid rules
////////////////////////////////////////

// floor of v/64, same rounding as a signed shift right by 6
function automatic int floor_div64(input int v);
   if (v >= 0)
      return v / 64;
   return -((-v + 63) / 64);
endfunction

// radial lines at 15/45/75 deg and their mirrors at 165/135/105
function automatic bit on_radial(input int x, input int y);
   int slopes [3];
   int resid;
   bit hit;
   // tan of each angle in 64ths
   slopes = '{17, 64, 240};
   hit = 1'b0;
   foreach (slopes[i]) begin
      for (int s = -1; s <= 1; s += 2) begin
         resid = floor_div64(x * slopes[i]) + s * y;
         if (resid < 0)
            resid = -resid;
         if (resid < `GRID_LINE_W / 2)
            hit = 1'b1;
      end
   end
   return hit;
endfunction

// ring bands in squared distance, upper half only
function automatic bit on_ring(input int x, input int y);
   int radii [6];
   int d2;
   bit hit;
   radii = '{`RING_1, `RING_2, `RING_3, `RING_4, `RING_5, `RING_6};
   d2 = x * x + y * y;
   hit = 1'b0;
   foreach (radii[i])
      if (d2 >= (radii[i] - `RING_W) ** 2 && d2 <= (radii[i] + `RING_W) ** 2)
         hit = 1'b1;
   return hit && (y >= 0);
endfunction

// grid colour of a raster position, blank off screen
function automatic rgb_t expected_grid(input int h, input int v);
   int x;
   int y;
   x = h - `ORIGIN_X;
   y = `ORIGIN_Y - v;
   if (h >= `H_ACTIVE || v >= `V_ACTIVE)
      return rgb_t'(`BLANK_COLOR);
   if (y < `VERT_OFFSET || on_radial(x, y) || on_ring(x, y))
      return rgb_t'(`GRID_COLOR);
   return rgb_t'(`BLANK_COLOR);
endfunction

// active low pulses, active flag over the visible area
function automatic sync_t expected_sync(input int h, input int v);
   sync_t s;
   s.hsync  = !(h >= `H_SYNC_START && h < `H_SYNC_END);
   s.vsync  = !(v >= `V_SYNC_START && v < `V_SYNC_END);
   s.active = (h < `H_ACTIVE) && (v < `V_ACTIVE);
   return s;
endfunction

// square marker test on both axes
function automatic bit in_marker(input int x, input int y, input int sx, input int sy);
   return (x - sx <= `MARK_HALF) && (sx - x <= `MARK_HALF) &&
          (y - sy <= `MARK_HALF) && (sy - y <= `MARK_HALF);
endfunction

`endif

/* verif/radar_scope_tb.sv */
`timescale 1ns/1ps
`include "scope_config.svh"

module radar_scope_tb import scope_pkg::*; ();

   localparam int FRAME_CYC = `H_TOTAL * `V_TOTAL;
   // three checked frames, run stops after four frames of cycles
   localparam int LAST_IDX  = 3 * FRAME_CYC - 1;
   localparam int LIMIT     = 4 * FRAME_CYC;

   logic        clk;
   logic        rst_n;
   logic        cmd_valid;
   logic        cmd_ready;
   target_cmd_t cmd;
   rgb_t        pixel;
   sync_t       video_sync;

   logic [31:0] lcg_state;
   int          cyc;
   bit          run_done;
   int          sync_errs;
   int          pix_errs;
   int          ready_errs;
   int          target_px;
   // slots as loaded, and as shown in the frame now leaving
   bit          pend_en [`NUM_TARGETS];
   int          pend_x  [`NUM_TARGETS];
   int          pend_y  [`NUM_TARGETS];
   bit          show_en [`NUM_TARGETS];
   int          show_x  [`NUM_TARGETS];
   int          show_y  [`NUM_TARGETS];

   `include "scope_model.svh"

   radar_scope_top radar_scope_top_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd        (cmd),
      .pixel      (pixel),
      .video_sync (video_sync)
   );

   always #4 clk = ~clk;

   // edges since reset release, same count the DUT counters see
   always @(posedge clk) begin
      if (rst_n)
         cyc <= cyc + 1;
   end

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return {17'd0, lcg_state[30:16]};
   endfunction

   // slot, enable and a position inside the upper grid area
   function automatic target_cmd_t random_cmd();
      target_cmd_t c;
      c.slot   = 2'(lcg_next() % `NUM_TARGETS);
      // about one in four commands clears its slot
      c.enable = (lcg_next() % 4) != 0;
      c.x      = 12'(int'(lcg_next() % 601) - 300);
      c.y      = 12'(int'(lcg_next() % 221) + 10);
      return c;
   endfunction

   // grid colour with shown markers laid over active pixels
   function automatic rgb_t expected_pixel(input int h, input int v);
      bit hit;
      hit = 1'b0;
      for (int i = 0; i < `NUM_TARGETS; i++)
         if (show_en[i] && in_marker(h - `ORIGIN_X, `ORIGIN_Y - v, show_x[i], show_y[i]))
            hit = 1'b1;
      if (hit && h < `H_ACTIVE && v < `V_ACTIVE)
         return rgb_t'(`TARGET_COLOR);
      return expected_grid(h, v);
   endfunction

   ////////////////////////////////////////
   // output checks, pipeline is 3 deep
   ////////////////////////////////////////
   task automatic check_outputs();
      int    n;
      int    m;
      int    h;
      int    v;
      sync_t exp_sync;
      rgb_t  exp_pix;
      logic  exp_ready;
      // n is the counter index now at the output, m the one in stage 1
      n = cyc - 3;
      m = cyc - 1;
      exp_sync  = '{hsync: 1'b1, vsync: 1'b1, active: 1'b0};
      exp_pix   = rgb_t'(`BLANK_COLOR);
      exp_ready = (m >= 0) && ((m / `H_TOTAL) % `V_TOTAL >= `V_ACTIVE);
      if (n >= 0) begin
         h = n % `H_TOTAL;
         v = (n / `H_TOTAL) % `V_TOTAL;
         // loads from the last vblank show from the frame start on
         if (h == 0 && v == 0) begin
            show_en = pend_en;
            show_x  = pend_x;
            show_y  = pend_y;
         end
         exp_sync = expected_sync(h, v);
         exp_pix  = expected_pixel(h, v);
         if (exp_pix == rgb_t'(`TARGET_COLOR))
            target_px++;
      end
      if (video_sync !== exp_sync) begin
         sync_errs++;
         $display("** Error at %0t: video_sync expected %b got %b", $time, exp_sync, video_sync);
      end
      if (pixel !== exp_pix) begin
         pix_errs++;
         $display("** Error at %0t: pixel expected %06h got %06h", $time, exp_pix, pixel);
      end
      if (cmd_ready !== exp_ready) begin
         ready_errs++;
         $display("** Error at %0t: cmd_ready expected %b got %b", $time, exp_ready, cmd_ready);
      end
      if (n == LAST_IDX)
         run_done = 1'b1;
   endtask

   // sample away from the rising edge
   always @(negedge clk) begin
      if (rst_n && !run_done)
         check_outputs();
   end

   ////////////////////////////////////////
   // command stimulus
   ////////////////////////////////////////
   initial begin : drive_commands
      int gap;
      wait (rst_n === 1'b1);
      @(posedge clk);
      forever begin
         gap = int'(lcg_next() % 48);
         repeat (gap) @(posedge clk);
         cmd_valid <= 1'b1;
         cmd       <= random_cmd();
         // hold valid and payload until the handshake edge
         do
            @(posedge clk);
         while (!(cmd_valid && cmd_ready));
         pend_en[cmd.slot] = cmd.enable;
         pend_x[cmd.slot]  = $signed(cmd.x);
         pend_y[cmd.slot]  = $signed(cmd.y);
         cmd_valid <= 1'b0;
      end
   end

   ////////////////////////////////////////
   // reset, run control and summary
   ////////////////////////////////////////
   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      cmd_valid = 1'b0;
      cmd       = '0;
      lcg_state = 32'd34330;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      while (!run_done && cyc < LIMIT)
         @(posedge clk);
      if (!run_done)
         $display("timeout: output checks did not finish within %0d cycles", LIMIT);
      if (target_px == 0)
         $display("no target marker was drawn in any checked frame");
      $display("errors: sync %0d, pixel %0d, cmd_ready %0d, total %0d",
               sync_errs, pix_errs, ready_errs, sync_errs + pix_errs + ready_errs);
      if (run_done && target_px > 0 && sync_errs + pix_errs + ready_errs == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule
